// ==== design/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_XLEN        32
`define MIPS_REG_BITS    5
`define MIPS_IMEM_WORDS  64
`define MIPS_DMEM_WORDS  64

`define MIPS_OP_RTYPE    6'h00
`define MIPS_OP_ADDIU    6'h09
`define MIPS_OP_LW       6'h23
`define MIPS_OP_SW       6'h2b
`define MIPS_OP_BEQ      6'h04
`define MIPS_OP_J        6'h02
`define MIPS_OP_HALT     6'h3f  // all ones

`define MIPS_FN_ADDU     6'h21
`define MIPS_FN_SUBU     6'h23
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_SLT      6'h2a

`endif

// ==== design/mips_pkg.sv ====
`default_nettype none
`include "mips_macros.svh"

package mips_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src;    // immediate operand, dest is rt
    alu_op_e alu_op;
    logic    halt;
  } ctrl_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RUN,
    ST_PAUSE,
    ST_DRAIN,
    ST_DONE
  } run_state_e;

  typedef struct packed {
    logic                  valid;
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] pc4;
  } if_id_t;

  typedef struct packed {
    logic                      valid;
    ctrl_t                     ctrl;
    logic [`MIPS_XLEN-1:0]     ra;
    logic [`MIPS_XLEN-1:0]     rb;
    logic [`MIPS_REG_BITS-1:0] rs;
    logic [`MIPS_REG_BITS-1:0] rt;
    logic [`MIPS_REG_BITS-1:0] rd;
    logic [`MIPS_XLEN-1:0]     imm;  // sign extended
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    ctrl_t                     ctrl;
    logic [`MIPS_XLEN-1:0]     alu;
    logic [`MIPS_XLEN-1:0]     store;
    logic [`MIPS_REG_BITS-1:0] dest;
  } ex_mem_t;

  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      halt;
    logic [`MIPS_XLEN-1:0]     value;
    logic [`MIPS_REG_BITS-1:0] dest;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== design/fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

interface fwd_if;
  logic [`MIPS_REG_BITS-1:0] mem_rd;     // from EX/MEM
  logic                      mem_wen;
  logic [`MIPS_XLEN-1:0]     mem_value;
  logic [`MIPS_REG_BITS-1:0] wb_rd;      // from MEM/WB
  logic                      wb_wen;
  logic [`MIPS_XLEN-1:0]     wb_value;

  modport producer (
    output mem_rd, mem_wen, mem_value, wb_rd, wb_wen, wb_value
  );

  modport consumer (
    input mem_rd, mem_wen, mem_value, wb_rd, wb_wen, wb_value
  );
endinterface

`default_nettype wire

// ==== design/run_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module run_control (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_start,
  input  logic i_stop,
  input  logic i_halt_decoded,
  input  logic i_halt_done,
  output logic o_pipe_en,
  output logic o_clear,
  output logic o_running,
  output logic o_end,
  output logic o_load_ok
);

  mips_pkg::run_state_e state;
  mips_pkg::run_state_e saved;     // state to resume after a pause
  mips_pkg::run_state_e run_next;

  // halt seen in decode moves on this edge, so the run becomes a drain
  assign run_next = i_halt_decoded ? mips_pkg::ST_DRAIN : mips_pkg::ST_RUN;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= mips_pkg::ST_IDLE;
      saved <= mips_pkg::ST_RUN;
    end else begin
      case (state)
        mips_pkg::ST_IDLE, mips_pkg::ST_DONE: begin
          if (i_start) state <= mips_pkg::ST_RUN;
        end
        mips_pkg::ST_RUN: begin
          if (i_stop) begin
            state <= mips_pkg::ST_PAUSE;
            saved <= run_next;
          end else begin
            state <= run_next;
          end
        end
        mips_pkg::ST_DRAIN: begin
          if (i_halt_done) begin
            state <= mips_pkg::ST_DONE;   // done wins over a stop
          end else if (i_stop) begin
            state <= mips_pkg::ST_PAUSE;
            saved <= mips_pkg::ST_DRAIN;
          end
        end
        mips_pkg::ST_PAUSE: begin
          if (!i_stop) state <= saved;
        end
        default: state <= mips_pkg::ST_IDLE;
      endcase
    end
  end

  assign o_load_ok = (state == mips_pkg::ST_IDLE) || (state == mips_pkg::ST_DONE);
  assign o_pipe_en = (state == mips_pkg::ST_RUN) || (state == mips_pkg::ST_DRAIN);
  assign o_clear   = i_start && o_load_ok;
  assign o_running = !o_load_ok;
  assign o_end     = (state == mips_pkg::ST_DONE);

  // the halt marker reaches MEM/WB only after decode turned the run into a drain
  a_halt_done_after_drain: assert property (@(posedge i_clk) disable iff (i_reset)
    i_halt_done |-> (state != mips_pkg::ST_IDLE) && (state != mips_pkg::ST_RUN));

endmodule

`default_nettype wire

// ==== design/cycle_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycle_counter (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_clear,
  input  logic        i_count_en,
  input  logic        i_retire,
  output logic [31:0] o_cycles,
  output logic [31:0] o_retired
);

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      o_cycles  <= '0;
      o_retired <= '0;
    end else begin
      if (i_count_en && (o_cycles != '1)) o_cycles <= o_cycles + 32'd1;    // saturate
      if (i_retire && (o_retired != '1)) o_retired <= o_retired + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== design/stage_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module stage_fetch (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_clear,
  input  logic                  i_enable,
  input  logic                  i_stall,
  input  logic                  i_halt,
  input  logic                  i_jump,
  input  logic [`MIPS_XLEN-1:0] i_jump_addr,
  input  logic                  i_load_wen,
  input  logic [`MIPS_XLEN-1:0] i_load_addr,  // word index
  input  logic [`MIPS_XLEN-1:0] i_load_data,
  output mips_pkg::if_id_t      o_if_id
);

  localparam int IA = $clog2(`MIPS_IMEM_WORDS);

  logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_WORDS];
  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pc4;
  logic                  halted;  // halt passed decode, fetch is over

  assign pc4 = pc + 32'd4;

  always_ff @(posedge i_clk) begin
    if (i_load_wen) imem[i_load_addr[IA-1:0]] <= i_load_data;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      pc            <= '0;
      halted        <= 1'b0;
      o_if_id.valid <= 1'b0;
    end else if (i_enable && !i_stall) begin
      if (i_halt || halted) begin
        halted        <= 1'b1;
        o_if_id.valid <= 1'b0;  // pc frozen, bubbles only
      end else if (i_jump) begin
        pc            <= i_jump_addr;
        o_if_id.valid <= 1'b0;  // squash the wrong-path fetch
      end else begin
        pc            <= pc4;
        o_if_id.valid <= 1'b1;
        o_if_id.instr <= imem[pc[IA+1:2]];
        o_if_id.pc4   <= pc4;
      end
    end
  end

  a_load_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
    i_load_wen |-> (i_load_addr < `MIPS_IMEM_WORDS));

endmodule

`default_nettype wire

// ==== design/stage_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module stage_decode (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_clear,
  input  logic                      i_enable,
  input  mips_pkg::if_id_t          i_if_id,
  fwd_if.consumer                   fwd,
  input  logic [`MIPS_REG_BITS-1:0] i_r_addr,
  output logic [`MIPS_XLEN-1:0]     o_r_data,
  output mips_pkg::id_ex_t          o_id_ex,
  output logic                      o_stall,
  output logic                      o_jump,
  output logic [`MIPS_XLEN-1:0]     o_jump_addr,
  output logic                      o_halt
);

  logic [`MIPS_XLEN-1:0]     regs [2**`MIPS_REG_BITS];
  logic [5:0]                opcode;
  logic [5:0]                funct;
  logic [`MIPS_REG_BITS-1:0] rs, rt, rd, ex_dest;
  logic [`MIPS_XLEN-1:0]     ra, rb, imm;
  logic                      is_beq, is_j, use_rs, use_rt;
  logic                      load_use, branch_hazard, ex_wen, mem_wen;
  mips_pkg::ctrl_t           ctrl;

  assign opcode = i_if_id.instr[31:26];
  assign rs     = i_if_id.instr[25:21];
  assign rt     = i_if_id.instr[20:16];
  assign rd     = i_if_id.instr[15:11];
  assign funct  = i_if_id.instr[5:0];
  assign imm    = {{16{i_if_id.instr[15]}}, i_if_id.instr[15:0]};

  // same-cycle write is visible to the read
  function automatic logic [`MIPS_XLEN-1:0] read_reg(input logic [`MIPS_REG_BITS-1:0] a);
    if (a == '0) return '0;
    if (fwd.wb_wen && (fwd.wb_rd == a)) return fwd.wb_value;
    return regs[a];
  endfunction

  always_ff @(posedge i_clk) begin
    if (fwd.wb_wen && (fwd.wb_rd != '0)) regs[fwd.wb_rd] <= fwd.wb_value;
  end

  assign ra       = read_reg(rs);
  assign rb       = read_reg(rt);
  assign o_r_data = read_reg(i_r_addr);  // debug port

  always_comb begin
    ctrl = '0;
    if (i_if_id.valid) begin
      case (opcode)
        `MIPS_OP_RTYPE: begin
          ctrl.reg_write = 1'b1;
          case (funct)
            `MIPS_FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
            `MIPS_FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
            `MIPS_FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
            `MIPS_FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
            `MIPS_FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
            default:       ctrl.reg_write = 1'b0;  // unknown funct, no-op
          endcase
        end
        `MIPS_OP_ADDIU: {ctrl.reg_write, ctrl.alu_src} = 2'b11;
        `MIPS_OP_LW:    {ctrl.reg_write, ctrl.mem_read, ctrl.alu_src} = 3'b111;
        `MIPS_OP_SW:    {ctrl.mem_write, ctrl.alu_src} = 2'b11;
        `MIPS_OP_HALT:  ctrl.halt = 1'b1;
        default:        ctrl = '0;  // beq and j finish here
      endcase
    end
  end

  assign is_beq = i_if_id.valid && (opcode == `MIPS_OP_BEQ);
  assign is_j   = i_if_id.valid && (opcode == `MIPS_OP_J);
  assign o_halt = i_if_id.valid && (opcode == `MIPS_OP_HALT);
  assign use_rs = i_if_id.valid && !is_j && !o_halt;
  assign use_rt = i_if_id.valid && ((opcode == `MIPS_OP_RTYPE) || (opcode == `MIPS_OP_SW) || is_beq);

  // hazards against the instruction now in EX, straight from ID/EX
  assign ex_dest = o_id_ex.ctrl.alu_src ? o_id_ex.rt : o_id_ex.rd;
  assign ex_wen  = o_id_ex.valid && o_id_ex.ctrl.reg_write && (ex_dest != '0);
  assign mem_wen = fwd.mem_wen && (fwd.mem_rd != '0);

  assign load_use = ex_wen && o_id_ex.ctrl.mem_read &&
                    ((use_rs && (rs == ex_dest)) || (use_rt && (rt == ex_dest)));
  assign branch_hazard = is_beq &&
                         ((ex_wen && ((rs == ex_dest) || (rt == ex_dest))) ||
                          (mem_wen && ((rs == fwd.mem_rd) || (rt == fwd.mem_rd))));
  assign o_stall = load_use || branch_hazard;

  assign o_jump      = !o_stall && (is_j || (is_beq && (ra == rb)));
  assign o_jump_addr = is_j ? {i_if_id.pc4[31:28], i_if_id.instr[25:0], 2'b00}
                            : i_if_id.pc4 + (imm << 2);

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      o_id_ex.valid <= 1'b0;
    end else if (i_enable) begin
      if (o_stall) begin
        o_id_ex.valid <= 1'b0;  // bubble into EX
        o_id_ex.ctrl  <= '0;
      end else begin
        o_id_ex <= '{valid: i_if_id.valid, ctrl: ctrl, ra: ra, rb: rb,
                     rs: rs, rt: rt, rd: rd, imm: imm};
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/stage_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module stage_execute (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_clear,
  input  logic             i_enable,
  input  mips_pkg::id_ex_t i_id_ex,
  fwd_if.consumer          fwd_in,
  fwd_if.producer          fwd_out,
  output mips_pkg::ex_mem_t o_ex_mem
);

  logic                      mem_ok, wb_ok;
  logic [`MIPS_XLEN-1:0]     op_a, op_b, alu_b, alu_res;
  logic [`MIPS_REG_BITS-1:0] dest;

  assign mem_ok = fwd_in.mem_wen && (fwd_in.mem_rd != '0);
  assign wb_ok  = fwd_in.wb_wen && (fwd_in.wb_rd != '0);

  // youngest result wins
  function automatic logic [`MIPS_XLEN-1:0] forward(input logic [`MIPS_REG_BITS-1:0] src,
                                                    input logic [`MIPS_XLEN-1:0] reg_val);
    if (mem_ok && (fwd_in.mem_rd == src)) return fwd_in.mem_value;
    if (wb_ok && (fwd_in.wb_rd == src)) return fwd_in.wb_value;
    return reg_val;
  endfunction

  assign op_a  = forward(i_id_ex.rs, i_id_ex.ra);
  assign op_b  = forward(i_id_ex.rt, i_id_ex.rb);
  assign alu_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : op_b;
  assign dest  = i_id_ex.ctrl.alu_src ? i_id_ex.rt : i_id_ex.rd;  // i-type writes rt

  always_comb begin
    case (i_id_ex.ctrl.alu_op)
      mips_pkg::ALU_SUB: alu_res = op_a - alu_b;
      mips_pkg::ALU_AND: alu_res = op_a & alu_b;
      mips_pkg::ALU_OR:  alu_res = op_a | alu_b;
      mips_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
      default:           alu_res = op_a + alu_b;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      o_ex_mem.valid <= 1'b0;
    end else if (i_enable) begin
      o_ex_mem <= '{valid: i_id_ex.valid, ctrl: i_id_ex.ctrl, alu: alu_res,
                    store: op_b, dest: dest};
    end
  end

  assign fwd_out.mem_rd    = o_ex_mem.dest;
  assign fwd_out.mem_wen   = o_ex_mem.valid && o_ex_mem.ctrl.reg_write;
  assign fwd_out.mem_value = o_ex_mem.alu;

  a_no_read_and_write: assert property (@(posedge i_clk) disable iff (i_reset)
    o_ex_mem.valid |-> !(o_ex_mem.ctrl.mem_read && o_ex_mem.ctrl.mem_write));

endmodule

`default_nettype wire

// ==== design/stage_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module stage_memory (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_clear,
  input  logic                  i_enable,
  input  mips_pkg::ex_mem_t     i_ex_mem,
  fwd_if.producer               fwd,
  input  logic [`MIPS_XLEN-1:0] i_r_addr,  // byte address
  output logic [`MIPS_XLEN-1:0] o_r_data,
  output logic                  o_retire,
  output logic                  o_halt_done
);

  localparam int DA = $clog2(`MIPS_DMEM_WORDS);

  logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_WORDS];
  logic [DA-1:0]         idx;
  logic [`MIPS_XLEN-1:0] wb_value;
  mips_pkg::mem_wb_t     mem_wb;

  assign idx      = i_ex_mem.alu[DA+1:2];  // word addressed
  assign wb_value = i_ex_mem.ctrl.mem_read ? dmem[idx] : i_ex_mem.alu;
  assign o_r_data = dmem[i_r_addr[DA+1:2]];

  always_ff @(posedge i_clk) begin
    if (i_enable && i_ex_mem.valid && i_ex_mem.ctrl.mem_write) dmem[idx] <= i_ex_mem.store;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      mem_wb.valid <= 1'b0;
    end else if (i_enable) begin
      mem_wb <= '{valid: i_ex_mem.valid, reg_write: i_ex_mem.ctrl.reg_write,
                  halt: i_ex_mem.ctrl.halt, value: wb_value, dest: i_ex_mem.dest};
    end
  end

  assign fwd.wb_rd    = mem_wb.dest;
  assign fwd.wb_wen   = mem_wb.valid && mem_wb.reg_write;
  assign fwd.wb_value = mem_wb.value;

  assign o_retire    = i_enable && i_ex_mem.valid && !i_ex_mem.ctrl.halt;  // one pulse each
  assign o_halt_done = mem_wb.valid && mem_wb.halt;

endmodule

`default_nettype wire

// ==== design/mips_lite_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module mips_lite_top (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_start,
  input  logic                      i_stop,
  input  logic                      i_load_wen,
  input  logic [`MIPS_XLEN-1:0]     i_load_addr,
  input  logic [`MIPS_XLEN-1:0]     i_load_data,
  input  logic [`MIPS_REG_BITS-1:0] i_r_addr_registers,
  input  logic [`MIPS_XLEN-1:0]     i_r_addr_data_mem,
  output logic [`MIPS_XLEN-1:0]     o_r_data_registers,
  output logic [`MIPS_XLEN-1:0]     o_r_data_data_mem,
  output logic                      o_running,
  output logic                      o_end,
  output logic [31:0]               o_cycles,
  output logic [31:0]               o_retired
);

  logic                  pipe_en, clear, load_ok, retire, halt_done;
  logic                  stall, jump, halt;
  logic [`MIPS_XLEN-1:0] jump_addr;
  mips_pkg::if_id_t      if_id;
  mips_pkg::id_ex_t      id_ex;
  mips_pkg::ex_mem_t     ex_mem;

  fwd_if u_fwd ();  // EX/MEM and MEM/WB destinations

  run_control u_run_control (
    .i_clk(i_clk), .i_reset(i_reset), .i_start(i_start), .i_stop(i_stop),
    .i_halt_decoded(halt), .i_halt_done(halt_done),
    .o_pipe_en(pipe_en), .o_clear(clear), .o_running(o_running),
    .o_end(o_end), .o_load_ok(load_ok)
  );

  cycle_counter u_cycle_counter (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(clear), .i_count_en(pipe_en),
    .i_retire(retire), .o_cycles(o_cycles), .o_retired(o_retired)
  );

  stage_fetch u_fetch (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(clear), .i_enable(pipe_en),
    .i_stall(stall), .i_halt(halt), .i_jump(jump), .i_jump_addr(jump_addr),
    .i_load_wen(i_load_wen && load_ok),  // loading only while idle
    .i_load_addr(i_load_addr), .i_load_data(i_load_data), .o_if_id(if_id)
  );

  stage_decode u_decode (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(clear), .i_enable(pipe_en),
    .i_if_id(if_id), .fwd(u_fwd.consumer),
    .i_r_addr(i_r_addr_registers), .o_r_data(o_r_data_registers),
    .o_id_ex(id_ex), .o_stall(stall), .o_jump(jump), .o_jump_addr(jump_addr),
    .o_halt(halt)
  );

  stage_execute u_execute (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(clear), .i_enable(pipe_en),
    .i_id_ex(id_ex), .fwd_in(u_fwd.consumer), .fwd_out(u_fwd.producer),
    .o_ex_mem(ex_mem)
  );

  stage_memory u_memory (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(clear), .i_enable(pipe_en),
    .i_ex_mem(ex_mem), .fwd(u_fwd.producer),
    .i_r_addr(i_r_addr_data_mem), .o_r_data(o_r_data_data_mem),
    .o_retire(retire), .o_halt_done(halt_done)
  );

endmodule

`default_nettype wire

// ==== bench/tb_mips_lite.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module tb_mips_lite;

  logic                      i_clk;
  logic                      i_reset;
  logic                      i_start;
  logic                      i_stop;
  logic                      i_load_wen;
  logic [`MIPS_XLEN-1:0]     i_load_addr;
  logic [`MIPS_XLEN-1:0]     i_load_data;
  logic [`MIPS_REG_BITS-1:0] i_r_addr_registers;
  logic [`MIPS_XLEN-1:0]     i_r_addr_data_mem;
  logic [`MIPS_XLEN-1:0]     o_r_data_registers;
  logic [`MIPS_XLEN-1:0]     o_r_data_data_mem;
  logic                      o_running;
  logic                      o_end;
  logic [31:0]               o_cycles;
  logic [31:0]               o_retired;

  // test file contents tagged by test number
  int                        word_owner[$];
  logic [`MIPS_XLEN-1:0]     word_data[$];
  int                        reg_owner[$];
  logic [`MIPS_REG_BITS-1:0] reg_idx[$];
  logic [`MIPS_XLEN-1:0]     reg_val[$];
  int                        mem_owner[$];
  logic [`MIPS_XLEN-1:0]     mem_addr[$];
  logic [`MIPS_XLEN-1:0]     mem_val[$];
  bit                        test_stop[$];
  logic [31:0]               test_retired[$];

  int cycle_limit = 0;  // set once the file is read
  int cycles_seen = 0;

  mips_lite_top UUT (
    .i_clk(i_clk), .i_reset(i_reset), .i_start(i_start), .i_stop(i_stop),
    .i_load_wen(i_load_wen), .i_load_addr(i_load_addr), .i_load_data(i_load_data),
    .i_r_addr_registers(i_r_addr_registers), .i_r_addr_data_mem(i_r_addr_data_mem),
    .o_r_data_registers(o_r_data_registers), .o_r_data_data_mem(o_r_data_data_mem),
    .o_running(o_running), .o_end(o_end), .o_cycles(o_cycles), .o_retired(o_retired)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles_seen = cycles_seen + 1;
    if ((cycle_limit > 0) && (cycles_seen > cycle_limit)) begin
      $display("timeout: the programs did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_count(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, expected));
  endtask

  task automatic check_level(input string what, input logic got, input logic expected);
    if (got !== expected)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, expected));
  endtask

  task automatic check_reg(input logic [`MIPS_REG_BITS-1:0] idx,
                           input logic [`MIPS_XLEN-1:0] expected);
    i_r_addr_registers = idx;
    @(negedge i_clk);  // debug read settled
    if (o_r_data_registers !== expected)
      report_mismatch($sformatf("register %0d is %h, expected %h",
                                idx, o_r_data_registers, expected));
    @(posedge i_clk);
    #10;
  endtask

  task automatic check_mem(input logic [`MIPS_XLEN-1:0] addr,
                           input logic [`MIPS_XLEN-1:0] expected);
    i_r_addr_data_mem = addr;
    @(negedge i_clk);
    if (o_r_data_data_mem !== expected)
      report_mismatch($sformatf("data word at %h is %h, expected %h",
                                addr, o_r_data_data_mem, expected));
    @(posedge i_clk);
    #10;
  endtask

  task automatic read_tests();
    int          fd;
    int          code;
    int          c;
    int          t;
    logic [63:0] key;
    logic [31:0] num;
    logic [31:0] a;
    logic [31:0] v;
    fd = $fopen("bench/mips_lite_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/mips_lite_tests.txt");
      $display("Errors found");
      $fatal(1, "no test file");
    end
    t = -1;
    while ($fscanf(fd, "%s", key) == 1) begin
      if (key == "#") begin
        c = 0;
        while ((c != 10) && (c != -1)) c = $fgetc(fd);  // skip comment line
      end else if (key == "test") begin
        code = $fscanf(fd, "%d", num);
        t = t + 1;
        test_stop.push_back(num[0]);
        test_retired.push_back(32'd0);
      end else if (key == "prog") begin
        code = $fscanf(fd, "%d", num);
        repeat (num) begin
          code = $fscanf(fd, "%h", v);
          word_owner.push_back(t);
          word_data.push_back(v);
        end
      end else if (key == "regs") begin
        code = $fscanf(fd, "%d", num);
        repeat (num) begin
          code = $fscanf(fd, "%d %h", a, v);
          reg_owner.push_back(t);
          reg_idx.push_back(a[`MIPS_REG_BITS-1:0]);
          reg_val.push_back(v);
        end
      end else if (key == "mems") begin
        code = $fscanf(fd, "%d", num);
        repeat (num) begin
          code = $fscanf(fd, "%h %h", a, v);
          mem_owner.push_back(t);
          mem_addr.push_back(a);
          mem_val.push_back(v);
        end
      end else if (key == "retired") begin
        code = $fscanf(fd, "%d", num);
        test_retired[t] = num;
      end else begin
        $display("unknown keyword %0s in the test file", key);
        $display("Errors found");
        $fatal(1, "bad test file");
      end
    end
    $fclose(fd);
  endtask

  task automatic load_program(input int t);
    logic [31:0] addr;
    addr = '0;
    foreach (word_owner[i]) begin
      if (word_owner[i] == t) begin
        i_load_wen  = 1'b1;
        i_load_addr = addr;  // word index
        i_load_data = word_data[i];
        @(posedge i_clk);
        #10;
        addr = addr + 32'd1;
      end
    end
    i_load_wen = 1'b0;
  endtask

  task automatic start_run();
    i_start = 1'b1;
    @(posedge i_clk);
    #10;
    i_start = 1'b0;
    check_count("cycles after start", o_cycles, 32'd0);
    check_count("retired after start", o_retired, 32'd0);
    check_level("o_running after start", o_running, 1'b1);
    check_level("o_end after start", o_end, 1'b0);
  endtask

  task automatic wait_for_end(input bit pulse_stop, output int run_cycles);
    int n;
    int len;
    n = 0;
    while (o_end !== 1'b1) begin
      @(posedge i_clk);
      #10;
      n = n + 1;
      if (pulse_stop && (n % 5 == 2) && !o_end) begin
        len = int'($urandom % 4) + 1;  // pause 1 to 4 cycles
        i_stop = 1'b1;
        repeat (len) begin
          @(posedge i_clk);
          #10;
        end
        i_stop = 1'b0;
        if (o_end) n = n + 1;  // drain finished on the first stopped edge
      end
    end
    run_cycles = n;  // edges the pipe was enabled for
  endtask

  initial begin
    int run_cycles;
    i_reset            = 1'b1;
    i_start            = 1'b0;
    i_stop             = 1'b0;
    i_load_wen         = 1'b0;
    i_load_addr        = '0;
    i_load_data        = '0;
    i_r_addr_registers = '0;
    i_r_addr_data_mem  = '0;
    void'($urandom(4));
    read_tests();
    cycle_limit = 200 * test_stop.size() + 20 * word_data.size();
    repeat (4) @(posedge i_clk);
    #10;
    i_reset = 1'b0;
    check_level("o_running after reset", o_running, 1'b0);
    check_level("o_end after reset", o_end, 1'b0);
    for (int t = 0; t < test_stop.size(); t++) begin
      load_program(t);
      start_run();
      wait_for_end(test_stop[t], run_cycles);
      check_level("o_running after halt", o_running, 1'b0);
      check_count("retired instructions", o_retired, test_retired[t]);
      check_count("cycles in the run", o_cycles, run_cycles);
      foreach (reg_owner[i]) begin
        if (reg_owner[i] == t) check_reg(reg_idx[i], reg_val[i]);
      end
      foreach (mem_owner[i]) begin
        if (mem_owner[i] == t) check_mem(mem_addr[i], mem_val[i]);
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mips_lite.f ====
+incdir+design
design/mips_pkg.sv
design/fwd_if.sv
design/run_control.sv
design/cycle_counter.sv
design/stage_fetch.sv
design/stage_decode.sv
design/stage_execute.sv
design/stage_memory.sv
design/mips_lite_top.sv
bench/tb_mips_lite.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_lite
FILELIST  ?= mips_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "TEST FAILED: no result in $(LOG)"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mips_lite_tests.txt ====
# keywords: test <stop pulses 0 or 1>, prog <n> <hex words>, regs <n> <reg> <hex value> pairs,
# mems <n> <hex byte address> <hex value> pairs, retired <executed non-halt count>
# alu and immediates with independent operands, r0 written but stays zero
test 0
prog 11
24010005 2402000C 2403FFFD 24000007 00222021 00612823
00433024 00223825 0061402A 0023482A FFFFFFFF
regs 10
0 00000000 1 00000005 2 0000000C 3 FFFFFFFD 4 00000011
5 FFFFFFF8 6 0000000C 7 0000000D 8 00000001 9 00000000
retired 10
# back to back dependences, forwarding from EX/MEM and MEM/WB
test 0
prog 11
24010003 00211021 00411821 00622023 2421000A 00242825
0081302A 24070001 24070002 00E04021 FFFFFFFF
regs 8
1 0000000D 2 00000006 3 00000009 4 00000003
5 0000000F 6 00000001 7 00000002 8 00000002
retired 10
# store then load, load-use stalls on rs, rt and store data
test 0
prog 11
24010040 24021234 AC220000 8C230000 00632021 AC240004
8C250004 AC250008 8C260008 24C70001 FFFFFFFF
regs 6
1 00000040 3 00001234 4 00002468 5 00002468 6 00002468 7 00002469
mems 3
40 00001234 44 00002468 48 00002468
retired 10
# taken and untaken beq, beq on a fresh register, j
test 0
prog 18
24030000 24040000 24070000 24080000 24010001 24020001
10220002 24030099 24040099 24050007 10A00001 24060008
0800000E 24070099 10000001 24080099 24090003 FFFFFFFF
regs 9
1 00000001 2 00000001 3 00000000 4 00000000 5 00000007
6 00000008 7 00000000 8 00000000 9 00000003
retired 13
# memory program again with new values and stop pulses
test 1
prog 11
24010040 24020777 AC220000 8C230000 00632021 AC240004
8C250004 AC250008 8C260008 24C70001 FFFFFFFF
regs 5
3 00000777 4 00000EEE 5 00000EEE 6 00000EEE 7 00000EEF
mems 3
40 00000777 44 00000EEE 48 00000EEE
retired 10
# branch program with stop pulses
test 1
prog 18
24030000 24040000 24070000 24080000 24010001 24020001
10220002 24030099 24040099 24050009 10A00001 24060008
0800000E 24070099 10000001 24080099 24090005 FFFFFFFF
regs 9
1 00000001 2 00000001 3 00000000 4 00000000 5 00000009
6 00000008 7 00000000 8 00000000 9 00000005
retired 13
